// File: logic/id_pkg.sv
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // major opcode inst[31:26]
    localparam logic [5:0] op6_grp0      = 6'h00;
    localparam logic [5:0] op6_lu12i     = 6'h05;
    localparam logic [5:0] op6_pcaddu12i = 6'h07;
    localparam logic [5:0] op6_mem       = 6'h0a;
    localparam logic [5:0] op6_jirl      = 6'h13;
    localparam logic [5:0] op6_b         = 6'h14;
    localparam logic [5:0] op6_bl        = 6'h15;
    localparam logic [5:0] op6_beq       = 6'h16;
    localparam logic [5:0] op6_bne       = 6'h17;
    localparam logic [5:0] op6_blt       = 6'h18;
    localparam logic [5:0] op6_bge       = 6'h19;
    localparam logic [5:0] op6_bltu      = 6'h1a;
    localparam logic [5:0] op6_bgeu      = 6'h1b;

    // inst[25:22], group 0
    localparam logic [3:0] op4_3r    = 4'h0;
    localparam logic [3:0] op4_shi   = 4'h1;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;
    // inst[25:22], load/store group
    localparam logic [3:0] op4_ld_b  = 4'h0;
    localparam logic [3:0] op4_ld_h  = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_b  = 4'h4;
    localparam logic [3:0] op4_st_h  = 4'h5;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_ld_bu = 4'h8;
    localparam logic [3:0] op4_ld_hu = 4'h9;

    localparam logic [1:0] op2_3r  = 2'h1; // inst[21:20]
    localparam logic [1:0] op2_shi = 2'h0;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    // one-hot, msb to lsb: lui sra srl sll xor or nor and sltu slt sub add
    typedef logic [alu_op_w-1:0] alu_op_t;

    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
        logic                  pending; // value not produced yet
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
        logic            stall;
    } br_t;

    typedef struct packed {
        logic beq, bne, blt, bge, bltu, bgeu;
        logic jirl, b, bl;
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [xlen-1:0]       imm;
        logic                  need_r1;
        logic                  need_r2;
        logic                  src_reg_is_rd; // second read through rd
        logic                  rf_we;
        logic [reg_addr_w-1:0] dest;
        logic                  mem_we;
        logic                  res_from_mem;
        logic                  mem_b, mem_h, mem_w;
        logic                  mem_unsigned;
        br_kind_t              br;
        logic [xlen-1:0]       br_offs;
    } decode_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [xlen-1:0]       alu_src1;
        logic [xlen-1:0]       alu_src2;
        logic                  res_from_mem;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rkd_value; // store data
        logic [xlen-1:0]       pc;
        logic                  mem_b, mem_h, mem_w;
        logic                  mem_unsigned;
    } ex_bus_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                            clk,
    input  logic [id_pkg::reg_addr_w-1:0]   raddr1,
    input  logic [id_pkg::reg_addr_w-1:0]   raddr2,
    output logic [id_pkg::xlen-1:0]         rdata1,
    output logic [id_pkg::xlen-1:0]         rdata2,
    input  id_pkg::fwd_t                    wr
);
    logic [id_pkg::xlen-1:0] rf [0:31];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin // r0 stays unwritten
            rf[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: logic/id_latch.sv
`timescale 1ns/100ps

module id_latch (
    input  logic               clk,
    input  logic               resetn,
    input  logic               if_to_id_valid,
    input  id_pkg::fetch_bus_t if_to_id_bus,
    input  logic               ex_allowin,
    input  logic               ready_go,
    input  logic               br_taken,
    output logic               id_allowin,
    output logic               id_valid,
    output id_pkg::fetch_bus_t id_inst_pc
);
    // a taken branch also frees the slot, which drops the wrong-path fetch
    assign id_allowin = !id_valid || (ready_go && ex_allowin) || br_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin // load on transfer only
            id_inst_pc <= if_to_id_bus;
        end
    end

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  id_pkg::fetch_bus_t inst_pc,
    output id_pkg::decode_t    dec
);
    logic [31:0] inst;
    logic [ 5:0] op_31_26;
    logic [ 3:0] op_25_22;
    logic [ 1:0] op_21_20;
    logic [ 4:0] op_19_15;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        grp0, is_3r, is_shi, is_mem;
    logic        inst_add, inst_sub, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_sll, inst_srl, inst_sra;
    logic        inst_slli, inst_srli, inst_srai;
    logic        inst_addi, inst_slti, inst_sltui;
    logic        inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i, inst_pcadd;
    logic        inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic        inst_st_b, inst_st_h, inst_st_w;
    logic        is_load, is_store, is_cbr, alu_3r, known;
    logic        need_ui5, need_si12, need_si20, src2_is_4;
    id_pkg::br_kind_t br;

    assign inst     = inst_pc.inst;
    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    assign grp0   = op_31_26 == id_pkg::op6_grp0;
    assign is_3r  = grp0 && op_25_22 == id_pkg::op4_3r && op_21_20 == id_pkg::op2_3r;
    assign is_shi = grp0 && op_25_22 == id_pkg::op4_shi && op_21_20 == id_pkg::op2_shi;
    assign is_mem = op_31_26 == id_pkg::op6_mem;

    assign inst_add  = is_3r && op_19_15 == id_pkg::op5_add;
    assign inst_sub  = is_3r && op_19_15 == id_pkg::op5_sub;
    assign inst_slt  = is_3r && op_19_15 == id_pkg::op5_slt;
    assign inst_sltu = is_3r && op_19_15 == id_pkg::op5_sltu;
    assign inst_nor  = is_3r && op_19_15 == id_pkg::op5_nor;
    assign inst_and  = is_3r && op_19_15 == id_pkg::op5_and;
    assign inst_or   = is_3r && op_19_15 == id_pkg::op5_or;
    assign inst_xor  = is_3r && op_19_15 == id_pkg::op5_xor;
    assign inst_sll  = is_3r && op_19_15 == id_pkg::op5_sll;
    assign inst_srl  = is_3r && op_19_15 == id_pkg::op5_srl;
    assign inst_sra  = is_3r && op_19_15 == id_pkg::op5_sra;
    assign inst_slli = is_shi && op_19_15 == id_pkg::op5_slli;
    assign inst_srli = is_shi && op_19_15 == id_pkg::op5_srli;
    assign inst_srai = is_shi && op_19_15 == id_pkg::op5_srai;

    assign inst_addi  = grp0 && op_25_22 == id_pkg::op4_addi;
    assign inst_slti  = grp0 && op_25_22 == id_pkg::op4_slti;
    assign inst_sltui = grp0 && op_25_22 == id_pkg::op4_sltui;
    assign inst_andi  = grp0 && op_25_22 == id_pkg::op4_andi;
    assign inst_ori   = grp0 && op_25_22 == id_pkg::op4_ori;
    assign inst_xori  = grp0 && op_25_22 == id_pkg::op4_xori;
    assign inst_lu12i = op_31_26 == id_pkg::op6_lu12i && !inst[25];
    assign inst_pcadd = op_31_26 == id_pkg::op6_pcaddu12i && !inst[25];

    assign inst_ld_b  = is_mem && op_25_22 == id_pkg::op4_ld_b;
    assign inst_ld_h  = is_mem && op_25_22 == id_pkg::op4_ld_h;
    assign inst_ld_w  = is_mem && op_25_22 == id_pkg::op4_ld_w;
    assign inst_ld_bu = is_mem && op_25_22 == id_pkg::op4_ld_bu;
    assign inst_ld_hu = is_mem && op_25_22 == id_pkg::op4_ld_hu;
    assign inst_st_b  = is_mem && op_25_22 == id_pkg::op4_st_b;
    assign inst_st_h  = is_mem && op_25_22 == id_pkg::op4_st_h;
    assign inst_st_w  = is_mem && op_25_22 == id_pkg::op4_st_w;

    assign br = '{beq:  op_31_26 == id_pkg::op6_beq,
                  bne:  op_31_26 == id_pkg::op6_bne,
                  blt:  op_31_26 == id_pkg::op6_blt,
                  bge:  op_31_26 == id_pkg::op6_bge,
                  bltu: op_31_26 == id_pkg::op6_bltu,
                  bgeu: op_31_26 == id_pkg::op6_bgeu,
                  jirl: op_31_26 == id_pkg::op6_jirl,
                  b:    op_31_26 == id_pkg::op6_b,
                  bl:   op_31_26 == id_pkg::op6_bl};

    assign is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store = inst_st_b | inst_st_h | inst_st_w;
    assign is_cbr   = br.beq | br.bne | br.blt | br.bge | br.bltu | br.bgeu;
    assign alu_3r   = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                    | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
    assign need_ui5  = inst_slli | inst_srli | inst_srai;
    assign need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
    assign need_si20 = inst_lu12i | inst_pcadd;
    assign src2_is_4 = br.jirl | br.bl; // link value pc+4
    // anything else decodes as a no-op
    assign known = alu_3r | need_ui5 | need_si12 | need_si20 | inst_andi | inst_ori
                 | inst_xori | is_cbr | br.jirl | br.b | br.bl;

    always_comb begin
        dec.alu_op = {inst_lu12i,
                      inst_sra | inst_srai,
                      inst_srl | inst_srli,
                      inst_sll | inst_slli,
                      inst_xor | inst_xori,
                      inst_or | inst_ori,
                      inst_nor,
                      inst_and | inst_andi,
                      inst_sltu | inst_sltui,
                      inst_slt | inst_slti,
                      inst_sub,
                      inst_add | inst_addi | is_load | is_store | src2_is_4 | inst_pcadd};
        dec.src1_is_pc  = src2_is_4 | inst_pcadd;
        dec.src2_is_imm = need_ui5 | need_si12 | need_si20 | src2_is_4
                        | inst_andi | inst_ori | inst_xori;
        dec.imm = src2_is_4              ? 32'd4 :
                  need_si20              ? {i20, 12'b0} :
                  (need_ui5 | need_si12) ? {{20{i12[11]}}, i12} :
                                           {20'b0, i12};
        dec.need_r1       = known & ~(br.b | br.bl | need_si20);
        dec.need_r2       = alu_3r | is_cbr | is_store;
        dec.src_reg_is_rd = is_cbr | is_store;
        dec.rf_we         = known & ~is_store & ~is_cbr & ~br.b;
        dec.dest          = br.bl ? 5'd1 : inst[4:0];
        dec.mem_we        = is_store;
        dec.res_from_mem  = is_load;
        dec.mem_b         = inst_ld_b | inst_ld_bu | inst_st_b;
        dec.mem_h         = inst_ld_h | inst_ld_hu | inst_st_h;
        dec.mem_w         = inst_ld_w | inst_st_w;
        dec.mem_unsigned  = inst_ld_bu | inst_ld_hu;
        dec.br            = br;
        dec.br_offs = (br.b | br.bl) ? {{4{i26[25]}}, i26, 2'b0}
                                     : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

// File: logic/operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
    input  id_pkg::decode_t               dec,
    input  logic [id_pkg::reg_addr_w-1:0] rj,
    input  logic [id_pkg::reg_addr_w-1:0] rkd,
    input  logic [id_pkg::xlen-1:0]       rdata1,
    input  logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::fwd_t                  ex_fwd,
    input  id_pkg::fwd_t                  mem_fwd,
    input  id_pkg::fwd_t                  wb_fwd,
    output logic [id_pkg::xlen-1:0]       rj_value,
    output logic [id_pkg::xlen-1:0]       rkd_value,
    output logic                          stall
);
    typedef struct packed {
        logic                    pending;
        logic [id_pkg::xlen-1:0] value;
    } pick_t;

    pick_t op1, op2;

    // first match wins, ex before mem before wb
    function automatic pick_t pick(input logic [id_pkg::reg_addr_w-1:0] addr,
                                   input logic need,
                                   input logic [id_pkg::xlen-1:0] rf_value,
                                   input id_pkg::fwd_t ex_f,
                                   input id_pkg::fwd_t mem_f,
                                   input id_pkg::fwd_t wb_f);
        logic  live;
        pick_t p;
        live = need && addr != '0; // r0 never forwarded
        if (live && ex_f.we && ex_f.waddr == addr) begin
            p = '{ex_f.pending, ex_f.wdata};
        end else if (live && mem_f.we && mem_f.waddr == addr) begin
            p = '{mem_f.pending, mem_f.wdata};
        end else if (live && wb_f.we && wb_f.waddr == addr) begin
            p = '{wb_f.pending, wb_f.wdata};
        end else begin
            p = '{1'b0, rf_value};
        end
        return p;
    endfunction

    assign op1 = pick(rj, dec.need_r1, rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign op2 = pick(rkd, dec.need_r2, rdata2, ex_fwd, mem_fwd, wb_fwd);

    assign rj_value  = op1.value;
    assign rkd_value = op2.value;
    assign stall     = op1.pending | op2.pending;

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input  id_pkg::decode_t         dec,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] rj_value,
    input  logic [id_pkg::xlen-1:0] rkd_value,
    input  logic                    id_valid,
    input  logic                    stall,
    output id_pkg::br_t             br
);
    logic eq, lt, ltu, cond;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    assign cond = (dec.br.beq  &&  eq)
               || (dec.br.bne  && !eq)
               || (dec.br.blt  &&  lt)
               || (dec.br.bge  && !lt)
               || (dec.br.bltu &&  ltu)
               || (dec.br.bgeu && !ltu)
               || dec.br.jirl || dec.br.b || dec.br.bl; // unconditional

    always_comb begin
        br.taken  = cond && id_valid && !stall;
        br.target = dec.br.jirl ? rj_value + dec.br_offs : pc + dec.br_offs;
        br.stall  = (|dec.br) && stall && id_valid; // target not known yet
    end

endmodule

// File: logic/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               if_to_id_valid,
    input  id_pkg::fetch_bus_t if_to_id_bus,
    output logic               id_allowin,
    output id_pkg::br_t        id_to_if_bus,
    input  logic               ex_allowin,
    output logic               id_to_ex_valid,
    output id_pkg::ex_bus_t    id_to_ex_bus,
    input  id_pkg::fwd_t       ex_fwd,
    input  id_pkg::fwd_t       mem_fwd,
    input  id_pkg::fwd_t       wb_fwd
);
    logic                          id_valid;
    logic                          ready_go;
    logic                          stall;
    id_pkg::fetch_bus_t            id_inst_pc;
    id_pkg::decode_t               dec;
    logic [id_pkg::reg_addr_w-1:0] rj, raddr2;
    logic [id_pkg::xlen-1:0]       rdata1, rdata2;
    logic [id_pkg::xlen-1:0]       rj_value, rkd_value;

    assign ready_go       = !stall;
    assign id_to_ex_valid = id_valid && ready_go;

    id_latch i_latch (
        .clk            (clk),
        .resetn         (resetn),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id_bus   (if_to_id_bus),
        .ex_allowin     (ex_allowin),
        .ready_go       (ready_go),
        .br_taken       (id_to_if_bus.taken),
        .id_allowin     (id_allowin),
        .id_valid       (id_valid),
        .id_inst_pc     (id_inst_pc)
    );

    inst_decoder i_decoder (
        .inst_pc (id_inst_pc),
        .dec     (dec)
    );

    assign rj     = id_inst_pc.inst[9:5];
    // branches and stores compare or store rd
    assign raddr2 = dec.src_reg_is_rd ? id_inst_pc.inst[4:0] : id_inst_pc.inst[14:10];

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb_fwd)
    );

    operand_forward i_forward (
        .dec       (dec),
        .rj        (rj),
        .rkd       (raddr2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit i_branch (
        .dec       (dec),
        .pc        (id_inst_pc.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .id_valid  (id_valid),
        .stall     (stall),
        .br        (id_to_if_bus)
    );

    always_comb begin
        id_to_ex_bus.alu_op       = dec.alu_op;
        id_to_ex_bus.alu_src1     = dec.src1_is_pc ? id_inst_pc.pc : rj_value;
        id_to_ex_bus.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
        id_to_ex_bus.res_from_mem = dec.res_from_mem && id_valid; // side effects need valid
        id_to_ex_bus.mem_we       = dec.mem_we && id_valid;
        id_to_ex_bus.rf_we        = dec.rf_we && id_valid;
        id_to_ex_bus.rf_waddr     = dec.dest;
        id_to_ex_bus.rkd_value    = rkd_value;
        id_to_ex_bus.pc           = id_inst_pc.pc;
        id_to_ex_bus.mem_b        = dec.mem_b;
        id_to_ex_bus.mem_h        = dec.mem_h;
        id_to_ex_bus.mem_w        = dec.mem_w;
        id_to_ex_bus.mem_unsigned = dec.mem_unsigned;
    end

endmodule

// File: test/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage;
    localparam int n_tests = 3000;

    // sub-opcode tables with entry 0 in the low bits
    localparam logic [54:0] op5_3r  = {5'h10, 5'h0f, 5'h0e, 5'h0b, 5'h0a, 5'h09,
                                       5'h08, 5'h05, 5'h04, 5'h02, 5'h00};
    localparam logic [14:0] op5_sh  = {5'h11, 5'h09, 5'h01};
    localparam logic [23:0] op4_imm = {4'hf, 4'he, 4'hd, 4'h9, 4'h8, 4'ha};
    localparam logic [31:0] op4_mem = {4'h6, 4'h5, 4'h4, 4'h9, 4'h8, 4'h2, 4'h1, 4'h0};

    logic               clk;
    logic               resetn;
    logic               if_to_id_valid;
    id_pkg::fetch_bus_t if_to_id_bus;
    logic               id_allowin;
    id_pkg::br_t        id_to_if_bus;
    logic               ex_allowin;
    logic               id_to_ex_valid;
    id_pkg::ex_bus_t    id_to_ex_bus;
    id_pkg::fwd_t       ex_fwd, mem_fwd, wb_fwd;

    integer             seed = 32'h525db79a;
    int                 errors = 0;
    int                 cur_kind, m_kind; // instruction class (39 for undefined)
    logic               m_valid, m_taken, m_allow;
    id_pkg::fetch_bus_t m_ip;
    logic [31:0]        shadow [0:31];

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] encode(input int k, input logic [31:0] r);
        logic [31:0] i;
        i = r;
        if (k <= 10) i[31:15] = {12'h001, op5_3r[k*5 +: 5]};
        else if (k <= 13) i[31:15] = {12'h004, op5_sh[(k-11)*5 +: 5]};
        else if (k <= 19) i[31:22] = {6'h00, op4_imm[(k-14)*4 +: 4]};
        else if (k <= 21) i[31:25] = {(k == 20) ? 6'h05 : 6'h07, 1'b0};
        else if (k <= 29) i[31:22] = {6'h0a, op4_mem[(k-22)*4 +: 4]};
        else if (k <= 38) i[31:26] = k - 11; // jirl 6'h13 up to bgeu 6'h1b
        else i[31:26] = r[0] ? 6'h3f : 6'h01;
        return i;
    endfunction

    function automatic int alu_bit(input int k);
        if (k == 4) return 5;
        if (k == 5) return 4;
        if (k <= 10) return k;
        if (k <= 13) return k - 3; // shift immediates
        if (k == 14) return 0;
        if (k == 15) return 2;
        if (k == 16) return 3;
        if (k == 17) return 4;
        if (k <= 19) return k - 12;
        if (k == 20) return 11;
        if (k <= 30 || k == 32) return 0; // addresses and link use add
        return -1;
    endfunction

    function automatic id_pkg::fwd_t random_fwd(input logic [31:0] r, input logic [31:0] data,
                                                input logic may_pend);
        return {r[0], 2'b00, r[3:1], data, may_pend && r[5:4] == 2'b00};
    endfunction

    task automatic mismatch(input string name, input logic [151:0] exp, input logic [151:0] got);
        errors++;
        $display("ERROR %s: expected %h, got %h at %0t", name, exp, got, $time);
    endtask

    task automatic operand(input logic [4:0] r, input logic need,
                           output logic [31:0] val, output logic pend);
        val  = shadow[r];
        pend = 1'b0;
        if (need && r != 5'd0) begin
            if (ex_fwd.we && ex_fwd.waddr == r) begin
                val  = ex_fwd.wdata;
                pend = ex_fwd.pending;
            end else if (mem_fwd.we && mem_fwd.waddr == r) begin
                val  = mem_fwd.wdata;
                pend = mem_fwd.pending;
            end else if (wb_fwd.we && wb_fwd.waddr == r) begin
                val  = wb_fwd.wdata;
                pend = wb_fwd.pending;
            end
        end
    endtask

    task automatic check_cycle();
        logic [31:0]     inst, imm, offs, a, b;
        logic            st, cbr, p1, p2, stall, cond;
        int              k, ai;
        id_pkg::ex_bus_t eb;
        id_pkg::br_t     ebr;
        inst = m_ip.inst;
        k    = m_kind;
        st   = k >= 27 && k <= 29;
        cbr  = k >= 33 && k <= 38;
        operand(inst[9:5], !(k == 20 || k == 21 || k == 31 || k == 32 || k == 39), a, p1);
        operand((st || cbr) ? inst[4:0] : inst[14:10], k <= 10 || st || cbr, b, p2);
        stall = p1 || p2;
        ai    = alu_bit(k);
        if (k == 30 || k == 32) imm = 32'd4;
        else if (k == 20 || k == 21) imm = {inst[24:5], 12'h000};
        else if (k >= 17 && k <= 19) imm = {20'h0, inst[21:10]};
        else imm = {{20{inst[21]}}, inst[21:10]};
        if (k == 31 || k == 32) offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        else offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        cond = (k >= 30 && k <= 32) || (k == 33 && a == b) || (k == 34 && a != b)
            || (k == 35 && $signed(a) < $signed(b)) || (k == 36 && $signed(a) >= $signed(b))
            || (k == 37 && a < b) || (k == 38 && a >= b);
        eb.alu_op = '0;
        if (ai >= 0) eb.alu_op[ai] = 1'b1;
        eb.alu_src1     = (k == 21 || k == 30 || k == 32) ? m_ip.pc : a;
        eb.alu_src2     = (k <= 10 || cbr || k == 31 || k == 39) ? b : imm;
        eb.res_from_mem = k >= 22 && k <= 26;
        eb.mem_we       = st;
        eb.rf_we        = !(st || cbr || k == 31 || k == 39);
        eb.rf_waddr     = (k == 32) ? 5'd1 : inst[4:0]; // bl links into r1
        eb.rkd_value    = b;
        eb.pc           = m_ip.pc;
        eb.mem_b        = k == 22 || k == 25 || k == 27;
        eb.mem_h        = k == 23 || k == 26 || k == 28;
        eb.mem_w        = k == 24 || k == 29;
        eb.mem_unsigned = k == 25 || k == 26;
        ebr.taken  = m_valid && !stall && cond;
        ebr.target = (k == 30) ? a + offs : m_ip.pc + offs;
        ebr.stall  = m_valid && stall && k >= 30 && k <= 38;
        m_taken = ebr.taken;
        m_allow = !m_valid || (!stall && ex_allowin) || ebr.taken;
        if (id_allowin !== m_allow) mismatch("id_allowin", m_allow, id_allowin);
        if (id_to_ex_valid !== (m_valid && !stall))
            mismatch("id_to_ex_valid", m_valid && !stall, id_to_ex_valid);
        if (id_to_if_bus.taken !== ebr.taken) mismatch("br.taken", ebr.taken, id_to_if_bus.taken);
        if (id_to_if_bus.stall !== ebr.stall) mismatch("br.stall", ebr.stall, id_to_if_bus.stall);
        if (m_valid && id_to_if_bus.target !== ebr.target)
            mismatch("br.target", ebr.target, id_to_if_bus.target);
        if (m_valid && id_to_ex_bus !== eb) mismatch("id_to_ex_bus", eb, id_to_ex_bus);
        if (!m_valid && id_to_ex_bus.rf_we !== 1'b0)
            mismatch("id_to_ex_bus.rf_we", 1'b0, id_to_ex_bus.rf_we);
        if (!m_valid && id_to_ex_bus.mem_we !== 1'b0)
            mismatch("id_to_ex_bus.mem_we", 1'b0, id_to_ex_bus.mem_we);
        if (!m_valid && id_to_ex_bus.res_from_mem !== 1'b0)
            mismatch("id_to_ex_bus.res_from_mem", 1'b0, id_to_ex_bus.res_from_mem);
    endtask

    task automatic drive_random();
        logic [31:0] r;
        int          k;
        k = $unsigned($random(seed)) % 40;
        r = $random(seed);
        if (k != 31 && k != 32) begin
            r[4:0] = {2'b00, r[2:0]}; // few registers give more forwarding hits
            r[9:5] = {2'b00, r[7:5]};
        end
        if (k <= 10) r[14:10] = {2'b00, r[12:10]};
        cur_kind       <= k;
        if_to_id_valid <= ($random(seed) & 3) != 0;
        if_to_id_bus   <= {encode(k, r), $random(seed) & 32'hffff_fffc};
        ex_allowin     <= ($random(seed) & 3) != 0;
        ex_fwd         <= random_fwd($random(seed), $random(seed), 1'b1);
        mem_fwd        <= random_fwd($random(seed), $random(seed), 1'b1);
        wb_fwd         <= random_fwd($random(seed), $random(seed), 1'b0);
    endtask

    // shadow register file and latch model
    always @(posedge clk) begin
        if (wb_fwd.we && wb_fwd.waddr != 5'd0) begin
            shadow[wb_fwd.waddr] <= wb_fwd.wdata;
        end
        if (!resetn) begin
            m_valid <= 1'b0;
        end else if (m_taken) begin
            m_valid <= 1'b0; // wrong-path fetch dropped
        end else if (m_allow) begin
            m_valid <= if_to_id_valid;
        end
        if (if_to_id_valid && m_allow) begin
            m_ip   <= if_to_id_bus;
            m_kind <= cur_kind;
        end
    end

    always @(negedge clk) begin
        if (resetn) begin
            check_cycle();
        end
    end

    initial begin
        int i;
        resetn         = 1'b0;
        if_to_id_valid = 1'b0;
        if_to_id_bus   = '0;
        ex_allowin     = 1'b1;
        ex_fwd         = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        cur_kind       = 0;
        shadow[0]      = '0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        if (id_to_ex_valid !== 1'b0) mismatch("id_to_ex_valid", 1'b0, id_to_ex_valid);
        if (id_to_if_bus.taken !== 1'b0) mismatch("br.taken", 1'b0, id_to_if_bus.taken);
        if (id_to_if_bus.stall !== 1'b0) mismatch("br.stall", 1'b0, id_to_if_bus.stall);
        if (id_allowin !== 1'b1) mismatch("id_allowin", 1'b1, id_allowin);
        @(posedge clk);
        for (i = 1; i < 32; i++) begin // preload every register through wb
            wb_fwd <= {1'b1, i[4:0], $random(seed), 1'b0};
            @(posedge clk);
        end
        for (i = 0; i < n_tests; i++) begin
            drive_random();
            @(posedge clk);
        end
        $display("%0d tests, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(n_tests * 20 * 20);
        $display("timeout: the test sequence did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: id_stage.f
logic/id_pkg.sv
logic/regfile.sv
logic/id_latch.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/id_stage.sv
test/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - logic/id_pkg.sv
      - logic/regfile.sv
      - logic/id_latch.sv
      - logic/inst_decoder.sv
      - logic/operand_forward.sv
      - logic/branch_unit.sv
      - logic/id_stage.sv
  - target: test
    files:
      - test/tb_id_stage.sv
